/* common/aa_pkg.sv */
// ------------------------------
// aa_pkg shared widths, encodings and bundles
// for the AXI-Lite / AXI-Stream mailbox bridge
// ------------------------------
package aa_pkg;

  // ------------------------------
  // widths and sizes
  // ------------------------------
  // data path and remote address width
  localparam int AA_DATA_W     = 32;
  localparam int AA_STRB_W     = 4;
  // local AXI-Lite address width
  localparam int LS_ADDR_W     = 15;
  // mailbox depth and word index width
  localparam int AA_MBOX_WORDS = 8;
  localparam int AA_IDX_W      = 3;

  // ------------------------------
  // address pages
  // ------------------------------
  // remote address bits 27:8
  localparam logic [19:0] REMOTE_MBOX_PAGE = 20'h00020;
  localparam logic [19:0] REMOTE_REG_PAGE  = 20'h00021;
  // local address bits 11:8
  localparam logic [3:0]  LOCAL_MBOX_PAGE  = 4'h0;
  localparam logic [3:0]  LOCAL_REG_PAGE   = 4'h1;

  // cycle type carried in tuser
  typedef enum logic [1:0] {
    SS_AXIS = 2'b00,
    SS_WR   = 2'b01,
    SS_RD   = 2'b10,
    SS_RS   = 2'b11
  } ss_cyc_e;

  // access target after address decode
  typedef enum logic [1:0] {
    TGT_NONE = 2'b00,
    TGT_MBOX = 2'b01,
    TGT_REG  = 2'b10
  } target_e;

  // one register file access, local or remote
  // for TGT_REG only index bit 0 matters: 0 enable, 1 status
  typedef struct packed {
    logic                  write;
    target_e               target;
    logic [AA_IDX_W-1:0]   index;
    logic [AA_DATA_W-1:0]  data;
    logic [AA_STRB_W-1:0]  strb;
  } reg_access_t;

  // stream beat without the valid/ready pair
  typedef struct packed {
    logic [AA_DATA_W-1:0]  tdata;
    logic [AA_STRB_W-1:0]  tstrb;
    logic [AA_STRB_W-1:0]  tkeep;
    logic                  tlast;
    ss_cyc_e               tuser;
  } stream_beat_t;

endpackage

/* rtl/aa_axil_slave.sv */
// ------------------------------
// aa_axil_slave turns local AXI-Lite writes and reads
// into single-cycle register file accesses
// ------------------------------
module aa_axil_slave import aa_pkg::*; (
  input  logic                  axis_clk,
  input  logic                  axis_rst_n,
  input  logic                  cc_aa_enable,
  input  logic                  s_awvalid,
  input  logic [LS_ADDR_W-1:0]  s_awaddr,
  input  logic                  s_wvalid,
  input  logic [AA_DATA_W-1:0]  s_wdata,
  input  logic [AA_STRB_W-1:0]  s_wstrb,
  input  logic                  s_arvalid,
  input  logic [LS_ADDR_W-1:0]  s_araddr,
  input  logic                  s_rready,
  input  logic [AA_DATA_W-1:0]  lcl_rdata,
  output logic                  s_awready,
  output logic                  s_wready,
  output logic                  s_arready,
  output logic                  s_rvalid,
  output logic [AA_DATA_W-1:0]  s_rdata,
  output logic                  lcl_valid,
  output reg_access_t           lcl_access
);

  typedef enum logic [1:0] {
    SL_IDLE,
    SL_WR_ACC,
    SL_RD_ACC,
    SL_RD_HOLD
  } slv_state_e;

  slv_state_e             state_q;
  slv_state_e             state_d;
  logic [LS_ADDR_W-1:0]   addr;
  logic [AA_DATA_W-1:0]   rdata_q;

  // page decode on address bits 11:8
  function automatic target_e local_target(input logic [3:0] page);
    if (page == LOCAL_MBOX_PAGE) return TGT_MBOX;
    if (page == LOCAL_REG_PAGE) return TGT_REG;
    return TGT_NONE;
  endfunction

  // ------------------------------
  // state machine
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      // write wins when both are pending
      SL_IDLE: begin
        if (cc_aa_enable && s_awvalid && s_wvalid) begin
          state_d = SL_WR_ACC;
        end else if (cc_aa_enable && s_arvalid) begin
          state_d = SL_RD_ACC;
        end
      end
      SL_WR_ACC: state_d = SL_IDLE;
      SL_RD_ACC: state_d = SL_RD_HOLD;
      // hold read data until the master takes it
      SL_RD_HOLD: begin
        if (s_rready) begin
          state_d = SL_IDLE;
        end
      end
      default: state_d = SL_IDLE;
    endcase
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state_q <= SL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // read data captured during the accept cycle
  always_ff @(posedge axis_clk) begin
    if (state_q == SL_RD_ACC) begin
      rdata_q <= lcl_rdata;
    end
  end

  // ------------------------------
  // channel handshakes and access
  // ------------------------------
  assign s_awready = (state_q == SL_WR_ACC);
  assign s_wready  = (state_q == SL_WR_ACC);
  assign s_arready = (state_q == SL_RD_ACC);
  assign s_rvalid  = (state_q == SL_RD_HOLD);
  assign s_rdata   = rdata_q;

  // one strobe per accepted write or read
  assign lcl_valid = s_awready || s_arready;
  assign addr      = s_awready ? s_awaddr : s_araddr;

  assign lcl_access.write  = s_awready;
  assign lcl_access.target = local_target(addr[11:8]);
  assign lcl_access.index  = (local_target(addr[11:8]) == TGT_REG) ?
                             {{(AA_IDX_W-1){1'b0}}, addr[2]} : addr[4:2];
  assign lcl_access.data   = s_wdata;
  assign lcl_access.strb   = s_wstrb;

endmodule

/* rtl/aa_mailbox.sv */
// ------------------------------
// aa_mailbox holds the mailbox words and interrupt regs,
// arbitrates local over remote, buffers remote read data
// ------------------------------
module aa_mailbox import aa_pkg::*; (
  input  logic                  axis_clk,
  input  logic                  axis_rst_n,
  input  logic                  lcl_valid,
  input  reg_access_t           lcl_access,
  input  logic                  rmt_req,
  input  reg_access_t           rmt_access,
  input  logic                  rsp_ack,
  output logic [AA_DATA_W-1:0]  lcl_rdata,
  output logic                  rmt_ack,
  output logic                  rsp_req,
  output logic [AA_DATA_W-1:0]  rsp_data,
  output logic                  mb_irq
);

  logic [AA_DATA_W-1:0]  mbox [AA_MBOX_WORDS];
  logic                  intr_enable;
  logic                  intr_status;
  logic                  rsp_empty;
  logic                  rmt_do;
  logic                  rd_load;
  logic                  wr_en;
  reg_access_t           wr_acc;
  logic                  status_clr;
  logic                  status_set;

  // zero for misses, bit 0 only for the registers
  function automatic logic [AA_DATA_W-1:0] read_word(input reg_access_t acc);
    case (acc.target)
      TGT_MBOX: return mbox[acc.index];
      TGT_REG:  return {{(AA_DATA_W-1){1'b0}}, acc.index[0] ? intr_status : intr_enable};
      default:  return '0;
    endcase
  endfunction

  // byte lanes from new_word where strb is set
  function automatic logic [AA_DATA_W-1:0] merge_bytes(input logic [AA_DATA_W-1:0] old_word,
                                                       input logic [AA_DATA_W-1:0] new_word,
                                                       input logic [AA_STRB_W-1:0] strb);
    logic [AA_DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < AA_STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------
  // arbitration
  // ------------------------------
  // remote waits for a free cycle, reads also for an empty buffer
  assign rsp_empty = !rsp_req && !rsp_ack;
  assign rmt_do    = rmt_req && !rmt_ack && !lcl_valid && (rmt_access.write || rsp_empty);
  assign rd_load   = rmt_do && !rmt_access.write;

  // single write port, local side first
  assign wr_acc = lcl_valid ? lcl_access : rmt_access;
  assign wr_en  = (lcl_valid && lcl_access.write) || (rmt_do && rmt_access.write);

  assign lcl_rdata = read_word(lcl_access);

  always_ff @(posedge axis_clk) begin
    if (wr_en && wr_acc.target == TGT_MBOX) begin
      mbox[wr_acc.index] <= merge_bytes(mbox[wr_acc.index], wr_acc.data, wr_acc.strb);
    end
  end

  // ------------------------------
  // interrupt registers
  // ------------------------------
  // write one to clear from the local side only
  assign status_clr = lcl_valid && lcl_access.write && lcl_access.target == TGT_REG &&
                      lcl_access.index[0] && lcl_access.strb[0] && lcl_access.data[0];
  assign status_set = rmt_do && rmt_access.write && rmt_access.target == TGT_MBOX &&
                      (|rmt_access.strb);

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      intr_enable <= 1'b0;
      intr_status <= 1'b0;
    end else begin
      if (wr_en && wr_acc.target == TGT_REG && !wr_acc.index[0] && wr_acc.strb[0]) begin
        intr_enable <= wr_acc.data[0];
      end
      if (status_clr) begin
        intr_status <= 1'b0;
      end else if (status_set) begin
        intr_status <= 1'b1;
      end
    end
  end

  assign mb_irq = intr_status && intr_enable;

  // ------------------------------
  // req/ack toward rx and tx
  // ------------------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rmt_ack <= 1'b0;
      rsp_req <= 1'b0;
    end else begin
      if (!rmt_req) begin
        rmt_ack <= 1'b0;
      end else if (rmt_do) begin
        rmt_ack <= 1'b1;
      end
      // buffer frees once tx acks
      if (rd_load) begin
        rsp_req <= 1'b1;
      end else if (rsp_ack) begin
        rsp_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge axis_clk) begin
    if (rd_load) begin
      rsp_data <= read_word(rmt_access);
    end
  end

endmodule

/* rtl/axil_axis_top.sv */
// ------------------------------
// axil_axis_top mailbox bridge between the local
// AXI-Lite slave port and the remote stream link
// ------------------------------
module axil_axis_top import aa_pkg::*; (
  input  logic                  axis_clk,
  input  logic                  axis_rst_n,
  // AXI-Lite slave
  input  logic                  s_awvalid,
  input  logic [LS_ADDR_W-1:0]  s_awaddr,
  output logic                  s_awready,
  input  logic                  s_wvalid,
  input  logic [AA_DATA_W-1:0]  s_wdata,
  input  logic [AA_STRB_W-1:0]  s_wstrb,
  output logic                  s_wready,
  input  logic                  s_arvalid,
  input  logic [LS_ADDR_W-1:0]  s_araddr,
  output logic                  s_arready,
  output logic [AA_DATA_W-1:0]  s_rdata,
  output logic                  s_rvalid,
  input  logic                  s_rready,
  // stream in
  input  stream_beat_t          as_aa,
  input  logic                  as_aa_tvalid,
  output logic                  aa_as_tready,
  // stream out
  output stream_beat_t          aa_as,
  output logic                  aa_as_tvalid,
  input  logic                  as_aa_tready,
  // misc
  input  logic                  cc_aa_enable,
  output logic                  mb_irq
);

  logic                  lcl_valid;
  reg_access_t           lcl_access;
  logic [AA_DATA_W-1:0]  lcl_rdata;
  logic                  rmt_req;
  logic                  rmt_ack;
  reg_access_t           rmt_access;
  logic                  rsp_req;
  logic                  rsp_ack;
  logic [AA_DATA_W-1:0]  rsp_data;

  // local path
  aa_axil_slave i_axil_slave (.*);

  // remote path, rx then mailbox then tx
  aa_stream_rx i_stream_rx (.*);

  aa_mailbox i_mailbox (.*);

  aa_stream_tx i_stream_tx (.*);

endmodule

/* run.sh */
#!/bin/sh
# compile and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=tb_axil_axis_sim

verilator --binary --assert -j 0 -f sources.f --top-module tb_axil_axis -o "$SIM"
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/"$SIM" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* sources.f */
common/aa_pkg.sv
rtl/aa_axil_slave.sv
stream/aa_stream_rx.sv
stream/aa_stream_tx.sv
rtl/aa_mailbox.sv
rtl/axil_axis_top.sv
verif/axil_axis_assertions.sv
verif/tb_axil_axis.sv

/* stream/aa_stream_rx.sv */
// ------------------------------
// aa_stream_rx collects remote write and read frames
// and hands them to the mailbox over req/ack
// ------------------------------
module aa_stream_rx import aa_pkg::*; (
  input  logic          axis_clk,
  input  logic          axis_rst_n,
  input  stream_beat_t  as_aa,
  input  logic          as_aa_tvalid,
  input  logic          rmt_ack,
  output logic          aa_as_tready,
  output logic          rmt_req,
  output reg_access_t   rmt_access
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_WDATA,
    RX_REQ,
    RX_WAIT_REL
  } rx_state_e;

  rx_state_e              state_q;
  logic                   beat_ok;
  logic [AA_DATA_W-1:0]   addr_q;
  logic [AA_DATA_W-1:0]   data_q;
  logic [AA_STRB_W-1:0]   strb_q;
  logic                   wr_q;
  target_e                tgt;

  // remote page decode on bits 27:8
  assign tgt = (addr_q[27:8] == REMOTE_MBOX_PAGE) ? TGT_MBOX :
               (addr_q[27:8] == REMOTE_REG_PAGE)  ? TGT_REG  : TGT_NONE;

  // ready only while collecting beats
  assign aa_as_tready = (state_q == RX_IDLE) || (state_q == RX_WDATA);
  assign beat_ok      = aa_as_tready && as_aa_tvalid;

  // ------------------------------
  // frame state machine
  // ------------------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state_q <= RX_IDLE;
    end else begin
      case (state_q)
        // axis and rs beats fall through and are dropped
        RX_IDLE: begin
          if (beat_ok && as_aa.tuser == SS_WR) begin
            state_q <= RX_WDATA;
          end else if (beat_ok && as_aa.tuser == SS_RD) begin
            state_q <= RX_REQ;
          end
        end
        // miss writes end here with no request
        RX_WDATA: begin
          if (beat_ok) begin
            state_q <= (tgt == TGT_NONE) ? RX_IDLE : RX_REQ;
          end
        end
        RX_REQ: begin
          if (rmt_ack) begin
            state_q <= RX_WAIT_REL;
          end
        end
        RX_WAIT_REL: begin
          if (!rmt_ack) begin
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // beat 1 gives address and strobes, beat 2 the data
  always_ff @(posedge axis_clk) begin
    if (beat_ok && state_q == RX_IDLE) begin
      addr_q <= as_aa.tdata;
      strb_q <= as_aa.tstrb;
      wr_q   <= (as_aa.tuser == SS_WR);
    end else if (beat_ok) begin
      data_q <= as_aa.tdata;
    end
  end

  assign rmt_req           = (state_q == RX_REQ);
  assign rmt_access.write  = wr_q;
  assign rmt_access.target = tgt;
  // register select comes from address bit 2
  assign rmt_access.index  = (tgt == TGT_REG) ?
                             {{(AA_IDX_W-1){1'b0}}, addr_q[2]} : addr_q[4:2];
  assign rmt_access.data   = data_q;
  assign rmt_access.strb   = strb_q;

endmodule

/* stream/aa_stream_tx.sv */
// ------------------------------
// aa_stream_tx sends one SS_RS beat per remote read
// ------------------------------
module aa_stream_tx import aa_pkg::*; (
  input  logic                  axis_clk,
  input  logic                  axis_rst_n,
  input  logic                  rsp_req,
  input  logic [AA_DATA_W-1:0]  rsp_data,
  input  logic                  as_aa_tready,
  output stream_beat_t          aa_as,
  output logic                  aa_as_tvalid,
  output logic                  rsp_ack
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_SEND,
    TX_ACK
  } tx_state_e;

  tx_state_e              state_q;
  logic [AA_DATA_W-1:0]   data_q;

  // ------------------------------
  // response state machine
  // ------------------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state_q <= TX_IDLE;
    end else begin
      case (state_q)
        // req seen high here is always a fresh rise
        TX_IDLE: begin
          if (rsp_req) begin
            state_q <= TX_SEND;
          end
        end
        TX_SEND: begin
          if (as_aa_tready) begin
            state_q <= TX_ACK;
          end
        end
        // ack held until the buffer drops req
        TX_ACK: begin
          if (!rsp_req) begin
            state_q <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // beat data frozen while tvalid is up
  always_ff @(posedge axis_clk) begin
    if (state_q == TX_IDLE && rsp_req) begin
      data_q <= rsp_data;
    end
  end

  assign aa_as_tvalid = (state_q == TX_SEND);
  assign rsp_ack      = (state_q == TX_ACK);
  assign aa_as        = '{tdata: data_q, tstrb: '1, tkeep: '1, tlast: 1'b1, tuser: SS_RS};

endmodule

/* verif/axil_axis_assertions.sv */
// ------------------------------
// protocol checks on the bridge ports
// ------------------------------
module axil_axis_bind import aa_pkg::*; (
  input logic                  axis_clk,
  input logic                  axis_rst_n,
  input logic                  s_awready,
  input logic                  s_wready,
  input logic                  s_rvalid,
  input logic                  s_rready,
  input logic [AA_DATA_W-1:0]  s_rdata,
  input stream_beat_t          aa_as,
  input logic                  aa_as_tvalid,
  input logic                  as_aa_tready,
  input logic                  mb_irq,
  input logic                  intr_status,
  input logic                  intr_enable
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  // stream beat frozen while stalled
  tx_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    aa_as_tvalid && !as_aa_tready |=> aa_as_tvalid && $stable(aa_as))
    else begin
      fail_cnt++;
      $error("aa_as beat dropped or changed before as_aa_tready");
    end

  // read data frozen while stalled
  rd_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
    else begin
      fail_cnt++;
      $error("s_rvalid or s_rdata changed before s_rready");
    end

  aw_w_pair: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    s_awready == s_wready)
    else begin
      fail_cnt++;
      $error("s_awready and s_wready differ");
    end

  irq_rule: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    mb_irq == (intr_status && intr_enable))
    else begin
      fail_cnt++;
      $error("mb_irq does not match intr_status and intr_enable");
    end

endmodule

bind axil_axis_top axil_axis_bind i_axil_axis_bind (
  .axis_clk     (axis_clk),
  .axis_rst_n   (axis_rst_n),
  .s_awready    (s_awready),
  .s_wready     (s_wready),
  .s_rvalid     (s_rvalid),
  .s_rready     (s_rready),
  .s_rdata      (s_rdata),
  .aa_as        (aa_as),
  .aa_as_tvalid (aa_as_tvalid),
  .as_aa_tready (as_aa_tready),
  .mb_irq       (mb_irq),
  .intr_status  (i_mailbox.intr_status),
  .intr_enable  (i_mailbox.intr_enable)
);

/* verif/tb_axil_axis.sv */
// ------------------------------
// testbench for the mailbox bridge, directed local
// and remote accesses against a byte-lane model
// ------------------------------
module tb_axil_axis import aa_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 4;
  // rough cycle budget per test, scaled by a margin for the watchdog
  localparam int T_RESET    = 10;
  localparam int T_MAILBOX  = 150;
  localparam int T_IRQ      = 100;
  localparam int T_REMOTE   = 300;
  localparam int T_MISS     = 250;
  localparam int T_ENABLE   = 80;
  localparam int MARGIN     = 3;
  localparam int WATCHDOG_CYCLES =
    MARGIN * (T_RESET + T_MAILBOX + T_IRQ + T_REMOTE + T_MISS + T_ENABLE);

  logic                  axis_clk;
  logic                  axis_rst_n;
  logic                  s_awvalid;
  logic [LS_ADDR_W-1:0]  s_awaddr;
  logic                  s_awready;
  logic                  s_wvalid;
  logic [AA_DATA_W-1:0]  s_wdata;
  logic [AA_STRB_W-1:0]  s_wstrb;
  logic                  s_wready;
  logic                  s_arvalid;
  logic [LS_ADDR_W-1:0]  s_araddr;
  logic                  s_arready;
  logic [AA_DATA_W-1:0]  s_rdata;
  logic                  s_rvalid;
  logic                  s_rready;
  stream_beat_t          as_aa;
  logic                  as_aa_tvalid;
  logic                  aa_as_tready;
  stream_beat_t          aa_as;
  logic                  aa_as_tvalid;
  logic                  as_aa_tready;
  logic                  cc_aa_enable;
  logic                  mb_irq;

  // reference model of the register file
  logic [AA_DATA_W-1:0]  mbox_m [AA_MBOX_WORDS];
  logic                  en_m;
  logic                  st_m;

  logic [31:0]           lfsr_q;
  stream_beat_t          rsp_q [$];
  int                    errors;
  int                    checks;

  axil_axis_top i_axil_axis_top (.*);

  always #(CLK_PERIOD / 2) axis_clk = ~axis_clk;

  // output beats collected when valid and ready meet at the next edge
  always @(negedge axis_clk) begin
    if (axis_rst_n && aa_as_tvalid && as_aa_tready) begin
      rsp_q.push_back(aa_as);
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------
  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // byte mask built from the strobes
  function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // all stimulus moves 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge axis_clk);
    #1;
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic reset_dut();
    axis_rst_n = 1'b0;
    repeat (T_RESET) @(posedge axis_clk);
    #1 axis_rst_n = 1'b1;
    check_bit("s_awready", s_awready, 1'b0);
    check_bit("s_wready", s_wready, 1'b0);
    check_bit("s_arready", s_arready, 1'b0);
    check_bit("s_rvalid", s_rvalid, 1'b0);
    check_bit("aa_as_tvalid", aa_as_tvalid, 1'b0);
    check_bit("aa_as_tready", aa_as_tready, 1'b1);
    check_bit("mb_irq", mb_irq, 1'b0);
  endtask

  // stall keeps enable low that many cycles with the valids held
  task automatic local_write(input logic [LS_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall);
    int waited;
    cc_aa_enable = (stall == 0);
    s_awaddr  = addr;
    s_wdata   = data;
    s_wstrb   = strb;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    repeat (stall) begin
      next_cycle();
      check_bit("s_awready", s_awready, 1'b0);
      check_bit("s_wready", s_wready, 1'b0);
    end
    cc_aa_enable = 1'b1;
    waited = 0;
    do begin
      next_cycle();
      waited++;
    end while (!s_awready && waited < 10);
    // both readies one cycle after the valids are seen
    check_eq("s_awready latency", waited, 1);
    check_bit("s_wready", s_wready, 1'b1);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    next_cycle();
    check_bit("s_awready", s_awready, 1'b0);
  endtask

  task automatic local_read(input logic [LS_ADDR_W-1:0] addr, input int stall,
                            output logic [31:0] data);
    int waited;
    int hold;
    logic [31:0] first;
    cc_aa_enable = (stall == 0);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    repeat (stall) begin
      next_cycle();
      check_bit("s_arready", s_arready, 1'b0);
    end
    cc_aa_enable = 1'b1;
    waited = 0;
    do begin
      next_cycle();
      waited++;
    end while (!s_arready && waited < 10);
    check_eq("s_arready latency", waited, 1);
    s_arvalid = 1'b0;
    next_cycle();
    check_bit("s_rvalid", s_rvalid, 1'b1);
    first = s_rdata;
    // rready held off a few cycles, data must not move
    hold = int'(rand_bits(2));
    repeat (hold) begin
      next_cycle();
      check_bit("s_rvalid", s_rvalid, 1'b1);
      check_eq("s_rdata", s_rdata, first);
    end
    s_rready = 1'b1;
    next_cycle();
    s_rready = 1'b0;
    check_bit("s_rvalid", s_rvalid, 1'b0);
    data = first;
  endtask

  task automatic send_beat(input logic [31:0] tdata, input logic [3:0] tstrb,
                           input ss_cyc_e tuser, input logic tlast);
    int waited;
    logic taken;
    as_aa = '{tdata: tdata, tstrb: tstrb, tkeep: 4'hf, tlast: tlast, tuser: tuser};
    as_aa_tvalid = 1'b1;
    waited = 0;
    do begin
      taken = aa_as_tready;
      next_cycle();
      waited++;
    end while (!taken && waited < 200);
    as_aa_tvalid = 1'b0;
    assert (taken) else begin
      errors++;
      $display("stream input beat was never accepted at %0t", $time);
    end
  endtask

  task automatic remote_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
    send_beat(addr, strb, SS_WR, 1'b0);
    send_beat(data, 4'h0, SS_WR, 1'b1);
  endtask

  task automatic remote_read(input logic [31:0] addr);
    send_beat(addr, 4'h0, SS_RD, 1'b1);
  endtask

  task automatic wait_beats(input int n);
    int waited;
    waited = 0;
    while (rsp_q.size() < n && waited < 100) begin
      next_cycle();
      waited++;
    end
  endtask

  task automatic check_beat(input logic [31:0] exp);
    stream_beat_t b;
    assert (rsp_q.size() > 0) else begin
      errors++;
      $display("expected a response beat but none arrived at %0t", $time);
    end
    if (rsp_q.size() > 0) begin
      b = rsp_q.pop_front();
      check_eq("aa_as.tdata", b.tdata, exp);
      check_eq("aa_as.tuser", 32'(b.tuser), 32'(SS_RS));
      check_eq("aa_as.tstrb", 32'(b.tstrb), 32'hf);
      check_eq("aa_as.tkeep", 32'(b.tkeep), 32'hf);
      check_bit("aa_as.tlast", b.tlast, 1'b1);
    end
  endtask

  // every mailbox word and both registers through the local port
  task automatic check_all_local();
    logic [31:0] d;
    for (int i = 0; i < AA_MBOX_WORDS; i++) begin
      local_read(LS_ADDR_W'(i * 4), 0, d);
      check_eq("s_rdata", d, mbox_m[i]);
    end
    local_read(15'h100, 0, d);
    check_eq("s_rdata", d, {31'b0, en_m});
    local_read(15'h104, 0, d);
    check_eq("s_rdata", d, {31'b0, st_m});
    // irq follows the modelled registers
    check_bit("mb_irq", mb_irq, en_m & st_m);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic mailbox_rw_test();
    logic [31:0] d;
    logic [3:0] s;
    // full words first so no lane is left unknown
    for (int i = 0; i < AA_MBOX_WORDS; i++) begin
      d = rand_bits(32);
      local_write(LS_ADDR_W'(i * 4), d, 4'hf, 0);
      mbox_m[i] = d;
    end
    for (int i = 0; i < AA_MBOX_WORDS; i++) begin
      d = rand_bits(32);
      s = AA_STRB_W'(rand_bits(4));
      local_write(LS_ADDR_W'(i * 4), d, s, 0);
      mbox_m[i] = apply_strobes(mbox_m[i], d, s);
    end
    check_all_local();
  endtask

  task automatic interrupt_test();
    logic [31:0] d;
    logic [3:0] s;
    int waited;
    local_write(15'h100, 32'h1, 4'h1, 0);
    en_m = 1'b1;
    check_bit("mb_irq", mb_irq, en_m & st_m);
    d = rand_bits(32);
    s = AA_STRB_W'(rand_bits(4)) | 4'h1;
    remote_write(32'h0000_2014, d, s);
    mbox_m[5] = apply_strobes(mbox_m[5], d, s);
    st_m = 1'b1;
    waited = 0;
    while (!mb_irq && waited < 50) begin
      next_cycle();
      waited++;
    end
    assert (mb_irq) else begin
      errors++;
      $display("mb_irq did not rise after the remote mailbox write");
    end
    local_read(15'h104, 0, d);
    check_eq("s_rdata", d, 32'h1);
    // write one to clear
    local_write(15'h104, 32'h1, 4'h1, 0);
    st_m = 1'b0;
    check_bit("mb_irq", mb_irq, en_m & st_m);
    local_read(15'h104, 0, d);
    check_eq("s_rdata", d, 32'h0);
    check_all_local();
  endtask

  task automatic remote_read_test();
    logic [31:0] exp_q [$];
    int n;
    int rounds;
    rsp_q.delete();
    for (int i = 0; i < AA_MBOX_WORDS; i++) begin
      exp_q.push_back(mbox_m[i]);
    end
    exp_q.push_back({31'b0, en_m});
    exp_q.push_back({31'b0, st_m});
    n = exp_q.size();
    rounds = 0;
    fork
      // reads issued back to back
      begin
        for (int i = 0; i < AA_MBOX_WORDS; i++) begin
          remote_read(32'h0000_2000 + 32'(i * 4));
        end
        remote_read(32'h0000_2100);
        remote_read(32'h0000_2104);
      end
      // output back-pressure in random stretches
      begin
        while (rsp_q.size() < n && rounds < 200) begin
          as_aa_tready = 1'b0;
          repeat (int'(rand_bits(3))) next_cycle();
          as_aa_tready = 1'b1;
          repeat (1 + int'(rand_bits(1))) next_cycle();
          rounds++;
        end
      end
    join
    check_eq("response beat count", rsp_q.size(), n);
    for (int i = 0; i < n; i++) begin
      check_beat(exp_q[i]);
    end
  endtask

  task automatic miss_test();
    logic [31:0] d;
    local_read(15'h200, 0, d);
    check_eq("s_rdata", d, 32'h0);
    local_write(15'h204, rand_bits(32), 4'hf, 0);
    check_all_local();
    rsp_q.delete();
    // outside both remote pages
    remote_read(32'h0000_3000);
    wait_beats(1);
    check_beat(32'h0);
    // frames that carry no access
    send_beat(32'h0000_2000, 4'hf, SS_AXIS, 1'b1);
    send_beat(rand_bits(32), 4'hf, SS_AXIS, 1'b1);
    send_beat(32'h0000_2104, 4'hf, SS_RS, 1'b1);
    send_beat(rand_bits(32), 4'hf, SS_RS, 1'b1);
    remote_write(32'h0000_3008, rand_bits(32), 4'hf);
    repeat (10) next_cycle();
    check_eq("response beat count", rsp_q.size(), 0);
    check_all_local();
  endtask

  task automatic enable_test();
    logic [31:0] d;
    logic [31:0] rd;
    d = rand_bits(32);
    local_write(15'h01c, d, 4'hf, 20);
    mbox_m[7] = d;
    local_read(15'h01c, 20, rd);
    check_eq("s_rdata", rd, d);
  endtask

  // ------------------------------
  // main sequence and watchdog
  // ------------------------------
  initial begin
    axis_clk     = 1'b0;
    axis_rst_n   = 1'b0;
    s_awvalid    = 1'b0;
    s_awaddr     = '0;
    s_wvalid     = 1'b0;
    s_wdata      = '0;
    s_wstrb      = '0;
    s_arvalid    = 1'b0;
    s_araddr     = '0;
    s_rready     = 1'b0;
    as_aa        = '0;
    as_aa_tvalid = 1'b0;
    as_aa_tready = 1'b1;
    cc_aa_enable = 1'b1;
    en_m         = 1'b0;
    st_m         = 1'b0;
    lfsr_q       = 32'hd44f5e7c;
    errors       = 0;
    checks       = 0;
    reset_dut();
    mailbox_rw_test();
    interrupt_test();
    remote_read_test();
    miss_test();
    enable_test();
    repeat (5) next_cycle();
    errors += i_axil_axis_top.i_axil_axis_bind.fail_cnt;
    $display("checks %0d errors %0d assertion failures %0d", checks, errors,
             i_axil_axis_top.i_axil_axis_bind.fail_cnt);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
